// ==== src/colmix_pkg.sv ====
// colour mixer shared types
// pixel, palette index, colour and sync types for the layer mixer
// plus the layer code of the priority word and the program port target

package colmix_pkg;

    // table geometry
    localparam int PAL_DEPTH = 256;          // entries per palette or priority table

    // low nibble of all ones marks a transparent pixel on every layer
    localparam logic [3:0] TRANSP_NIB = 4'hf;

    typedef logic [3:0] char_pxl_t;          // character layer pixel
    typedef logic [5:0] scr_pxl_t;           // scroll layer pixel
    typedef logic [7:0] obj_pxl_t;           // object pixel, 7:6 priority, 5:0 colour
    typedef logic [3:0] nib_t;               // table word
    typedef logic [7:0] pal_idx_t;           // palette or table address

    // the four layer pixels of one raster position
    typedef struct packed {
        char_pxl_t chr;
        scr_pxl_t  scr1;
        scr_pxl_t  scr2;
        obj_pxl_t  obj;
    } layer_px_t;

    // 12-bit output colour
    typedef struct packed {
        nib_t red;
        nib_t green;
        nib_t blue;
    } rgb_t;

    // blanking flags, high while the beam is in the visible area
    typedef struct packed {
        logic lhbl;                          // horizontal display on
        logic lvbl;                          // vertical display on
    } sync_t;

    // low two bits of the priority word
    typedef enum logic [1:0] {
        LAYER_SCR2 = 2'd0,
        LAYER_SCR1 = 2'd1,
        LAYER_OBJ  = 2'd2,
        LAYER_CHR  = 2'd3
    } layer_e;

    // program port target
    typedef enum logic [1:0] {
        TBL_RED   = 2'd0,
        TBL_GREEN = 2'd1,
        TBL_BLUE  = 2'd2,
        TBL_PRIO  = 2'd3
    } table_e;

endpackage

// ==== src/palette_table.sv ====
// palette table
// 256 x 4 writable memory in place of a palette or priority PROM
// synchronous write from the program port, registered read on every clk
// so an address set on one pixel enable is settled before the next

`timescale 1ns/1ps

module palette_table (
    input  logic                 clk,
    input  logic                 we,
    input  colmix_pkg::pal_idx_t wr_addr,
    input  colmix_pkg::nib_t     din,
    input  colmix_pkg::pal_idx_t rd_addr,
    output colmix_pkg::nib_t     q
);
    import colmix_pkg::*;

    nib_t mem [PAL_DEPTH];                   // table contents survive reset

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;             // visible to reads from next clk
        end
    end

    // read port runs every clk, not on the pixel enable
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

// ==== src/layer_priority.sv ====
// layer priority stage
// registers the four layer pixels on the pixel enable and builds the
// priority table address from the layer opacity flags and the object
// priority bits; the table output is the priority word for layer select
// single scroll plane boards use a reduced address

`timescale 1ns/1ps

module layer_priority #(
    parameter int SCR_PLANES = 2             // 1 or 2 scroll planes
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pix_cen,
    input  colmix_pkg::layer_px_t px,
    input  logic [3:0]            layer_en,  // bit 0 chr, 1 scr1, 2 scr2, 3 obj
    input  logic                  prio_we,
    input  colmix_pkg::pal_idx_t  prog_addr,
    input  colmix_pkg::nib_t      prog_din,
    output colmix_pkg::layer_px_t px_q,
    output colmix_pkg::nib_t      prio
);
    import colmix_pkg::*;

    logic     chr_opq;                       // char layer opaque
    logic     scr1_opq;                      // front scroll opaque
    logic     obj_opq;                       // object opaque
    pal_idx_t prio_addr_d;
    pal_idx_t prio_addr;

    // scr2 is the backdrop, it has no opacity input to the table
    assign chr_opq  = layer_en[0] && (px.chr != TRANSP_NIB);
    assign scr1_opq = layer_en[1] && (px.scr1[3:0] != TRANSP_NIB);
    assign obj_opq  = layer_en[3] && (px.obj[3:0] != TRANSP_NIB);

    // priority address
    always_comb begin
        prio_addr_d    = '0;
        prio_addr_d[4] = chr_opq;
        prio_addr_d[3] = obj_opq;
        if (SCR_PLANES == 2) begin
            prio_addr_d[2:1] = px.obj[7:6];  // both object priority bits
            prio_addr_d[0]   = scr1_opq;
        end else begin
            prio_addr_d[1]   = px.obj[6];    // only one priority bit on this board
        end
    end

    // pixel and address registers, one enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            px_q      <= '0;
            prio_addr <= '0;
        end else if (pix_cen) begin
            px_q      <= px;
            prio_addr <= prio_addr_d;
        end
    end

    // priority table, read one clk after the address
    palette_table u_prio_table (
        .clk     (clk),
        .we      (prio_we),
        .wr_addr (prog_addr),
        .din     (prog_din),
        .rd_addr (prio_addr),
        .q       (prio)
    );

endmodule

// ==== src/layer_select.sv ====
// layer select stage
// picks the colour of the layer named by the priority word and joins
// it with the bank bits into the 8-bit palette index
// on single scroll plane boards both scroll codes pick scr1

`timescale 1ns/1ps

module layer_select #(
    parameter int SCR_PLANES = 2             // 1 or 2 scroll planes
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pix_cen,
    input  colmix_pkg::layer_px_t px_q,
    input  colmix_pkg::nib_t      prio,      // 3:2 bank, 1:0 layer
    output colmix_pkg::pal_idx_t  pal_idx
);
    import colmix_pkg::*;

    layer_e   sel;
    scr_pxl_t colour;                        // 6-bit colour of the chosen layer

    assign sel = layer_e'(prio[1:0]);

    // colour mux
    always_comb begin
        case (sel)
            LAYER_SCR2: begin
                if (SCR_PLANES == 2) begin
                    colour = px_q.scr2;
                end else begin
                    colour = px_q.scr1;      // no second plane, fold onto scr1
                end
            end
            LAYER_SCR1: colour = px_q.scr1;
            LAYER_OBJ:  colour = px_q.obj[5:0];      // drop object priority bits
            default:    colour = {2'b00, px_q.chr};  // char is only 4 bits wide
        endcase
    end

    // index register, bank on top of the colour
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pal_idx <= '0;
        end else if (pix_cen) begin
            pal_idx <= {prio[3:2], colour};
        end
    end

endmodule

// ==== src/palette_lookup.sv ====
// palette lookup stage
// three colour tables turn the palette index into 12-bit rgb
// the blanking flags ride a three enable shift register so they leave
// together with the pixel they belong to; rgb is black while blanked

`timescale 1ns/1ps

module palette_lookup (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pix_cen,
    input  colmix_pkg::pal_idx_t pal_idx,
    input  colmix_pkg::sync_t    sync_in,
    input  logic                 red_we,
    input  logic                 green_we,
    input  logic                 blue_we,
    input  colmix_pkg::pal_idx_t prog_addr,
    input  colmix_pkg::nib_t     prog_din,
    output colmix_pkg::rgb_t     rgb,
    output colmix_pkg::sync_t    sync_out
);
    import colmix_pkg::*;

    rgb_t          pal_rgb;                  // table outputs, settle one clk after index
    sync_t [2:0]   sync_dly;                 // one entry per pipeline stage
    logic          disp_on;

    palette_table u_red_table (
        .clk     (clk),
        .we      (red_we),
        .wr_addr (prog_addr),
        .din     (prog_din),
        .rd_addr (pal_idx),
        .q       (pal_rgb.red)
    );

    palette_table u_green_table (
        .clk     (clk),
        .we      (green_we),
        .wr_addr (prog_addr),
        .din     (prog_din),
        .rd_addr (pal_idx),
        .q       (pal_rgb.green)
    );

    palette_table u_blue_table (
        .clk     (clk),
        .we      (blue_we),
        .wr_addr (prog_addr),
        .din     (prog_din),
        .rd_addr (pal_idx),
        .q       (pal_rgb.blue)
    );

    // sync entering the third position, same pixel as the colour now
    // being registered
    assign disp_on = sync_dly[1].lhbl && sync_dly[1].lvbl;

    // blank delay
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_dly <= '0;                  // blanked out of reset
        end else if (pix_cen) begin
            sync_dly <= {sync_dly[1:0], sync_in};
        end
    end

    // output colour register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= '0;
        end else if (pix_cen) begin
            rgb <= disp_on ? pal_rgb : '0;   // force black in blanking
        end
    end

    assign sync_out = sync_dly[2];

endmodule

// ==== src/colmix_top.sv ====
// colour mixer top
// priority, layer select and palette lookup stages on the pixel enable
// fixed latency of three enables from layer pixels to rgb and sync_out
// the program port writes one of the four tables, picked by prog_sel
// pix_cen must be low for at least one clk between enables

`timescale 1ns/1ps

module colmix_top #(
    parameter int SCR_PLANES = 2             // 1 or 2 scroll planes
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pix_cen,
    input  colmix_pkg::layer_px_t px,
    input  colmix_pkg::sync_t     sync_in,
    input  logic [3:0]            layer_en,
    input  logic                  prog_we,
    input  colmix_pkg::table_e    prog_sel,
    input  colmix_pkg::pal_idx_t  prog_addr,
    input  colmix_pkg::nib_t      prog_din,
    output colmix_pkg::rgb_t      rgb,
    output colmix_pkg::sync_t     sync_out
);
    import colmix_pkg::*;

    layer_px_t px_q;                         // stage 1 pixels
    nib_t      prio;                         // priority word
    pal_idx_t  pal_idx;                      // stage 2 index
    logic      red_we;
    logic      green_we;
    logic      blue_we;
    logic      prio_we;

    // program target decode
    assign red_we   = prog_we && (prog_sel == TBL_RED);
    assign green_we = prog_we && (prog_sel == TBL_GREEN);
    assign blue_we  = prog_we && (prog_sel == TBL_BLUE);
    assign prio_we  = prog_we && (prog_sel == TBL_PRIO);

    layer_priority #(.SCR_PLANES(SCR_PLANES)) u_layer_priority (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_cen   (pix_cen),
        .px        (px),
        .layer_en  (layer_en),
        .prio_we   (prio_we),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .px_q      (px_q),
        .prio      (prio)
    );

    layer_select #(.SCR_PLANES(SCR_PLANES)) u_layer_select (
        .clk     (clk),
        .arst_n  (arst_n),
        .pix_cen (pix_cen),
        .px_q    (px_q),
        .prio    (prio),
        .pal_idx (pal_idx)
    );

    palette_lookup u_palette_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_cen   (pix_cen),
        .pal_idx   (pal_idx),
        .sync_in   (sync_in),
        .red_we    (red_we),
        .green_we  (green_we),
        .blue_we   (blue_we),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .rgb       (rgb),
        .sync_out  (sync_out)
    );

endmodule

// ==== verification/colmix_asserts.sv ====
// colour mixer assertions
// bound to the top level, checks the blanking output, the reset
// state of the sync delay and the spacing of the pixel enable

`timescale 1ns/1ps

module colmix_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic                pix_cen,
    input colmix_pkg::rgb_t    rgb,
    input colmix_pkg::sync_t   sync_out
);

    // black whenever the delayed sync shows blanking
    a_blank_black: assert property (@(posedge clk) disable iff (!arst_n)
        !(sync_out.lhbl && sync_out.lvbl) |-> (rgb == '0))
        else $error("rgb not black while sync_out shows blanking");

    // first clk out of reset, no enable seen yet
    a_reset_blank: assert property (@(posedge clk)
        $rose(arst_n) |-> (sync_out == '0 && rgb == '0))
        else $error("sync_out or rgb not zero after reset");

    // at least one idle clk between enables
    a_cen_spacing: assert property (@(posedge clk) disable iff (!arst_n)
        pix_cen |=> !pix_cen)
        else $error("pix_cen high on two clk in a row");

endmodule

bind colmix_top colmix_asserts u_colmix_asserts (
    .clk      (clk),
    .arst_n   (arst_n),
    .pix_cen  (pix_cen),
    .rgb      (rgb),
    .sync_out (sync_out)
);

// ==== verification/colmix_tb.sv ====
// colour mixer testbench
// directed tests and a seeded random stream checked against a reference
// model of the opacity, priority, layer select and palette rules
// expectations ride a three-deep queue to match the pipeline latency

`timescale 1ns/1ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int CEN_DIV     = 4;          // one pixel enable in four clk
    localparam int DIR_STEPS   = 16;         // pixels per directed test
    localparam int RAND_BURSTS = 10;
    localparam int RAND_STEPS  = 40;         // pixels per random burst
    localparam int RAND_WRITES = 24;         // table writes before each burst
    // enables and program clks of the whole run, two full table loads
    localparam int TOTAL_ENABLES = 8 + 4 * (DIR_STEPS + 2) + RAND_BURSTS * (RAND_STEPS + 2);
    localparam int PROG_CLKS     = 8 * PAL_DEPTH + 32 + RAND_BURSTS * RAND_WRITES;
    localparam int WATCHDOG_NS   = (TOTAL_ENABLES * CEN_DIV + PROG_CLKS + 500) * CLK_PERIOD;
    localparam sync_t DISP_ON    = 2'b11;

    typedef struct packed {
        rgb_t  rgb;
        sync_t sync;
    } expect_t;

    logic       clk;
    logic       arst_n;
    logic       pix_cen;
    layer_px_t  px;
    sync_t      sync_in;
    logic [3:0] layer_en;
    logic       prog_we;
    table_e     prog_sel;
    pal_idx_t   prog_addr;
    nib_t       prog_din;
    rgb_t       rgb;
    sync_t      sync_out;

    // reference copies of the four tables
    nib_t red_tbl [PAL_DEPTH];
    nib_t green_tbl [PAL_DEPTH];
    nib_t blue_tbl [PAL_DEPTH];
    nib_t prio_tbl [PAL_DEPTH];

    expect_t exp_q[$];                       // oldest entry is two enables back
    string   test_name;
    int      err_count;
    int      pass_count;
    int      err_at_start;
    int      seed;

    colmix_top #(.SCR_PLANES(2)) u_colmix_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_cen   (pix_cen),
        .px        (px),
        .sync_in   (sync_in),
        .layer_en  (layer_en),
        .prog_we   (prog_we),
        .prog_sel  (prog_sel),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .rgb       (rgb),
        .sync_out  (sync_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // priority table address on a two plane board
    function automatic pal_idx_t model_prio_addr(layer_px_t p, logic [3:0] en);
        logic chr_on;
        logic scr1_on;
        logic obj_on;
        chr_on  = en[0] && (p.chr != 4'hf);
        scr1_on = en[1] && (p.scr1[3:0] != 4'hf);
        obj_on  = en[3] && (p.obj[3:0] != 4'hf);
        return {3'b000, chr_on, obj_on, p.obj[7:6], scr1_on};
    endfunction

    // expected rgb and sync for one sampled pixel
    function automatic expect_t model_pixel(layer_px_t p, sync_t s, logic [3:0] en);
        nib_t       pw;
        logic [5:0] colour;
        pal_idx_t   idx;
        expect_t    e;
        pw = prio_tbl[model_prio_addr(p, en)];
        case (pw[1:0])
            2'd0:    colour = p.scr2;
            2'd1:    colour = p.scr1;
            2'd2:    colour = p.obj[5:0];
            default: colour = {2'b00, p.chr};        // char zero extended
        endcase
        idx    = {pw[3:2], colour};                  // bank above colour
        e.sync = s;
        if (s.lhbl && s.lvbl) begin
            e.rgb = {red_tbl[idx], green_tbl[idx], blue_tbl[idx]};
        end else begin
            e.rgb = '0;                              // black in blanking
        end
        return e;
    endfunction

    // base table contents from every address bit
    function automatic nib_t base_fill(table_e sel, pal_idx_t a);
        case (sel)
            TBL_RED:   return a[7:4] ^ a[3:0];
            TBL_GREEN: return a[7:4] + ~a[3:0];
            TBL_BLUE:  return {a[1:0], a[7:6]} ^ a[5:2];
            default:   return {a[4] ^ a[0] ^ a[7], a[3], a[2:1] ^ {a[4], a[0]} ^ a[6:5]};
        endcase
    endfunction

    function automatic layer_px_t random_px();
        return layer_px_t'(24'($random(seed)));
    endfunction

    // random pixel with no transparent layer
    function automatic layer_px_t opaque_px();
        layer_px_t p;
        p          = random_px();
        p.chr[0]   = 1'b0;
        p.scr1[1]  = 1'b0;
        p.scr2[2]  = 1'b0;
        p.obj[3]   = 1'b0;
        return p;
    endfunction

    task automatic check_rgb(rgb_t exp, rgb_t act);
        if (act !== exp) begin
            $display("ERROR %s: rgb expected %h actual %h", test_name, exp, act);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_sync(sync_t exp, sync_t act);
        if (act !== exp) begin
            $display("ERROR %s: sync_out expected %b actual %b", test_name, exp, act);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    // one table write of one clk
    task automatic prog_table(table_e sel, pal_idx_t addr, nib_t din);
        prog_we   = 1'b1;
        prog_sel  = sel;
        prog_addr = addr;
        prog_din  = din;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        case (sel)
            TBL_RED:   red_tbl[addr] = din;
            TBL_GREEN: green_tbl[addr] = din;
            TBL_BLUE:  blue_tbl[addr] = din;
            default:   prio_tbl[addr] = din;
        endcase
    endtask

    // all four tables from the base pattern
    // inv_addr takes the pattern of the inverted address
    task automatic load_tables(logic inv_addr);
        pal_idx_t src;
        for (int t = 0; t < 4; t++) begin
            for (int a = 0; a < PAL_DEPTH; a++) begin
                src = inv_addr ? ~8'(a) : 8'(a);
                prog_table(table_e'(2'(t)), 8'(a), base_fill(table_e'(2'(t)), src));
            end
        end
    endtask

    // one pixel enable and the check of the pixel two enables back
    task automatic pixel_step(layer_px_t p, sync_t s, logic [3:0] en);
        expect_t e;
        px       = p;
        sync_in  = s;
        layer_en = en;
        pix_cen  = 1'b1;
        exp_q.push_back(model_pixel(p, s, en));
        @(posedge clk);
        #1;
        pix_cen = 1'b0;
        e = exp_q.pop_front();
        check_rgb(e.rgb, rgb);
        check_sync(e.sync, sync_out);
        repeat (CEN_DIV - 1) begin           // pix_cen low for three clk
            @(posedge clk);
            #1;
        end
    endtask

    // blank pixels so table writes never meet a visible pixel in flight
    task automatic flush();
        pixel_step('0, '0, 4'h0);
        pixel_step('0, '0, 4'h0);
    endtask

    task automatic start_test(string name);
        test_name    = name;
        err_at_start = err_count;
    endtask

    task automatic end_test();
        $display("%-14s done, %0d errors", test_name, err_count - err_at_start);
    endtask

    task automatic test_reset_blank();
        start_test("reset_blank");
        check_rgb('0, rgb);
        check_sync('0, sync_out);
        load_tables(1'b1);                   // non-black palette behind the blanking
        for (int i = 0; i < 8; i++) begin
            pixel_step(random_px(), sync_t'(2'(i % 3)), 4'hf);   // never both on
        end
        end_test();
    endtask

    task automatic test_layer_choice();
        layer_px_t p;
        start_test("layer_choice");
        load_tables(1'b0);
        for (int i = 0; i < DIR_STEPS; i++) begin
            p          = opaque_px();
            p.obj[7:6] = 2'(i);              // walks the layer code
            pixel_step(p, DISP_ON, 4'hf);
        end
        flush();
        end_test();
    endtask

    task automatic test_opacity();
        layer_px_t p;
        start_test("opacity");
        for (int i = 0; i < DIR_STEPS; i++) begin
            p = opaque_px();
            if (i[0]) p.chr = 4'hf;
            if (i[1]) p.scr1[3:0] = 4'hf;
            if (i[2]) p.obj[3:0] = 4'hf;
            if (i[3]) p.scr2[3:0] = 4'hf;    // backdrop has no address bit
            pixel_step(p, DISP_ON, 4'hf);
        end
        flush();
        end_test();
    endtask

    task automatic test_layer_enable();
        start_test("layer_enable");
        for (int i = 0; i < DIR_STEPS; i++) begin
            pixel_step(opaque_px(), DISP_ON, 4'(i));
        end
        flush();
        end_test();
    endtask

    task automatic test_bank_prio();
        layer_px_t p;
        nib_t      pw;
        start_test("bank_prio");
        for (int a = 0; a < 32; a++) begin
            pw = {2'(a >> 1) ^ 2'(a >> 3), (a % 2 == 1) ? 2'd2 : 2'd3};  // bank follows obj bits
            prog_table(TBL_PRIO, 8'(a), pw);
        end
        for (int i = 0; i < DIR_STEPS; i++) begin
            p          = opaque_px();
            p.obj[7:6] = 2'(i);
            if (i[2]) p.scr1[3:0] = 4'hf;
            if (i[3]) p.chr = 4'hf;
            pixel_step(p, DISP_ON, 4'hf);
        end
        flush();
        end_test();
    endtask

    task automatic test_random_stream();
        sync_t      s;
        logic [3:0] en;
        int         blank_left;
        int         r;
        start_test("random_stream");
        blank_left = 0;
        for (int b = 0; b < RAND_BURSTS; b++) begin
            for (int w = 0; w < RAND_WRITES; w++) begin
                prog_table(table_e'(2'($random(seed))), 8'($random(seed)), 4'($random(seed)));
            end
            for (int i = 0; i < RAND_STEPS; i++) begin
                if (blank_left == 0 && ($random(seed) & 15) == 0) begin
                    blank_left = 1 + ($random(seed) & 3);   // short blanking run
                end
                s = DISP_ON;
                if (blank_left > 0) begin
                    r = $random(seed) & 3;
                    s = (r == 3) ? sync_t'(2'b00) : sync_t'(2'(r));
                    blank_left--;
                end
                en = (($random(seed) & 3) == 0) ? 4'($random(seed)) : 4'hf;
                pixel_step(random_px(), s, en);
            end
            flush();
        end
        end_test();
    endtask

    initial begin
        seed         = 32'h1228_22fb;
        err_count    = 0;
        pass_count   = 0;
        err_at_start = 0;
        arst_n       = 1'b0;
        pix_cen      = 1'b0;
        px           = '0;
        sync_in      = '0;
        layer_en     = '0;
        prog_we      = 1'b0;
        prog_sel     = TBL_RED;
        prog_addr    = '0;
        prog_din     = '0;
        exp_q.push_back(expect_t'(14'd0));   // blank pipeline out of reset
        exp_q.push_back(expect_t'(14'd0));
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_blank();
        test_layer_choice();
        test_opacity();
        test_layer_enable();
        test_bank_prio();
        test_random_stream();
        $display("checks passed %0d, errors %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/colmix_pkg.sv
src/palette_table.sv
src/layer_priority.sv
src/layer_select.sv
src/palette_lookup.sv
src/colmix_top.sv
verification/colmix_asserts.sv
verification/colmix_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the colour mixer testbench with Verilator and runs it
# exits non-zero on a build error or when the log holds the fail message

LOG=sim.log

verilator --binary --timing --assert --top-module colmix_tb -f project.f \
    -o colmix_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/colmix_sim > "$LOG" 2>&1 || echo "simulator exited with an error"
cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "no pass message in $LOG"; exit 1; }
echo "simulation passed"
